//--- verilog/ob_config.svh
`ifndef OB_CONFIG_SVH
`define OB_CONFIG_SVH

// Order field widths
`define OB_PRICE_W 10
`define OB_QTY_W 8
`define OB_UID_W 8

// Command and response codes
`define OB_OPCODE_W 4
`define OB_STATUS_W 3

// Resting entries held per book side
`define OB_BOOK_DEPTH 4

`endif

//--- verilog/ob_pkg.sv
`include "ob_config.svh"

package ob_pkg;

  // Order values
  typedef logic [`OB_PRICE_W-1:0] price_t;
  typedef logic [`OB_QTY_W-1:0] quantity_t;
  typedef logic [`OB_UID_W-1:0] uid_t;

  // Command and response codes
  typedef logic [`OB_OPCODE_W-1:0] opcode_t;
  typedef logic [`OB_STATUS_W-1:0] status_t;

  // Index into one side's entry table
  typedef logic [$clog2(`OB_BOOK_DEPTH)-1:0] slot_t;

  // Opcodes accepted on the command port
  localparam opcode_t OP_NOP = opcode_t'(0);
  localparam opcode_t OP_QRY_BID_ASK = opcode_t'(1);
  localparam opcode_t OP_BUY_LIMIT = opcode_t'(2);
  localparam opcode_t OP_SELL_LIMIT = opcode_t'(3);
  localparam opcode_t OP_POP_TOP_BID = opcode_t'(4);
  localparam opcode_t OP_POP_TOP_ASK = opcode_t'(5);
  localparam opcode_t OP_CANCEL = opcode_t'(6);

  // Response statuses
  localparam status_t S_OKAY = status_t'(0);
  localparam status_t S_BAD = status_t'(1);
  localparam status_t S_REJECT = status_t'(2);
  localparam status_t S_BAD_POP = status_t'(3);
  localparam status_t S_CANCEL_HIT = status_t'(4);
  localparam status_t S_CANCEL_MISS = status_t'(5);
  // Trade report, one per head match
  localparam status_t S_TRADE = status_t'(6);

endpackage

//--- verilog/ob_cntrl_pkg.sv
package ob_cntrl_pkg;

  // Controller states
  typedef enum logic [1:0] {
    IDLE,
    // Register the head compare
    MATCH_QRY,
    // Trade on the registered compare, or finish
    MATCH_EXEC,
    // Collect the registered cancel hits
    CANCEL_RESP
  } cntrl_state_t;

  // Micro-operations from decode
  typedef enum logic [2:0] {
    OPK_NOP,
    OPK_SPREAD,
    OPK_INSERT_BID,
    OPK_INSERT_ASK,
    OPK_POP_BID,
    OPK_POP_ASK,
    OPK_CANCEL,
    OPK_BAD
  } op_kind_t;

  // Event kinds towards the response stage
  typedef enum logic [1:0] {
    EVK_STATUS,
    EVK_SPREAD,
    EVK_ENTRY,
    EVK_TRADE
  } evt_kind_t;

endpackage

//--- verilog/ob_cntrl_if.sv
`timescale 1ns/1ps
`include "ob_config.svh"

// Micro-operation from decode to execute
interface ob_op_if import ob_cntrl_pkg::*; ();
  logic op_vld;
  op_kind_t op_kind;
  logic [`OB_UID_W-1:0] op_uid;
  logic [`OB_UID_W-1:0] op_uid1;
  logic [`OB_PRICE_W-1:0] op_price;
  logic [`OB_QTY_W-1:0] op_quantity;
  // Pulses when execute retires the operation
  logic op_done;

  modport decode (output op_vld, op_kind, op_uid, op_uid1, op_price, op_quantity,
                  input op_done);
  modport execute (input op_vld, op_kind, op_uid, op_uid1, op_price, op_quantity,
                   output op_done);
endinterface

// Single-cycle event from execute to result
interface ob_evt_if import ob_cntrl_pkg::*; ();
  logic evt_vld;
  evt_kind_t evt_kind;
  logic [`OB_STATUS_W-1:0] evt_status;
  logic [`OB_UID_W-1:0] evt_uid;
  logic [`OB_UID_W-1:0] evt_uid1;
  logic [`OB_PRICE_W-1:0] evt_price_bid;
  logic [`OB_PRICE_W-1:0] evt_price_ask;
  logic [`OB_QTY_W-1:0] evt_quantity;

  modport execute (output evt_vld, evt_kind, evt_status, evt_uid, evt_uid1,
                   evt_price_bid, evt_price_ask, evt_quantity);
  modport result (input evt_vld, evt_kind, evt_status, evt_uid, evt_uid1,
                  evt_price_bid, evt_price_ask, evt_quantity);
endinterface

//--- verilog/ob_decode.sv
`timescale 1ns/1ps

module ob_decode import ob_pkg::*, ob_cntrl_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      cmd_vld,
  input  opcode_t   cmd_opcode,
  input  uid_t      cmd_uid,
  input  uid_t      cmd_uid1,
  input  price_t    cmd_price,
  input  quantity_t cmd_quantity,
  output logic      cmd_pop,
  ob_op_if.decode   op
);

  logic cmd_fetch;
  op_kind_t kind_w;

  // Take a command when the latch is free or frees this cycle
  assign cmd_fetch = cmd_vld & (~op.op_vld | op.op_done);
  assign cmd_pop = cmd_fetch;

  // Opcode to micro-operation
  always_comb begin
    case (cmd_opcode)
      OP_NOP:         kind_w = OPK_NOP;
      OP_QRY_BID_ASK: kind_w = OPK_SPREAD;
      OP_BUY_LIMIT:   kind_w = OPK_INSERT_BID;
      OP_SELL_LIMIT:  kind_w = OPK_INSERT_ASK;
      OP_POP_TOP_BID: kind_w = OPK_POP_BID;
      OP_POP_TOP_ASK: kind_w = OPK_POP_ASK;
      OP_CANCEL:      kind_w = OPK_CANCEL;
      // Unknown codes answer bad
      default:        kind_w = OPK_BAD;
    endcase
  end

  // Latch occupancy
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      op.op_vld <= 1'b0;
    end else if (cmd_fetch) begin
      op.op_vld <= 1'b1;
    end else if (op.op_done) begin
      op.op_vld <= 1'b0;
    end
  end

  // Latched command fields
  always_ff @(posedge clk) begin
    if (cmd_fetch) begin
      op.op_kind <= kind_w;
      op.op_uid <= cmd_uid;
      op.op_uid1 <= cmd_uid1;
      op.op_price <= cmd_price;
      op.op_quantity <= cmd_quantity;
    end
  end

  // Execute retires only a pending operation
  property p_done_pending;
    @(posedge clk) disable iff (!rst_n)
    op.op_done |-> op.op_vld;
  endproperty

  a_done_pending: assert property (p_done_pending)
    else $error("op_done without a pending operation");

endmodule

//--- verilog/ob_book_side.sv
`timescale 1ns/1ps
`include "ob_config.svh"

module ob_book_side import ob_pkg::*; #(
  parameter bit IS_ASK = 1'b0
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      insert,
  input  uid_t      ins_uid,
  input  price_t    ins_price,
  input  quantity_t ins_quantity,
  input  logic      pop_head,
  input  logic      head_update,
  input  quantity_t head_quantity_new,
  input  logic      cancel,
  input  uid_t      cancel_uid,
  output logic      cancel_hit,
  output logic      full,
  output logic      head_vld,
  output uid_t      head_uid,
  output price_t    head_price,
  output quantity_t head_quantity
);

  localparam int DEPTH = `OB_BOOK_DEPTH;

  logic [DEPTH-1:0] vld_r;
  uid_t uid_r [DEPTH];
  price_t price_r [DEPTH];
  quantity_t qty_r [DEPTH];

  slot_t head_slot;
  slot_t free_slot;
  logic free_found;
  logic [DEPTH-1:0] cancel_match;

  // Best price wins; strict compare keeps the lowest slot on ties
  always_comb begin
    head_vld = 1'b0;
    head_slot = '0;
    for (int i = 0; i < DEPTH; i++) begin
      if (vld_r[i]) begin
        if (!head_vld) begin
          head_vld = 1'b1;
          head_slot = slot_t'(i);
        end else if (IS_ASK ? (price_r[i] < price_r[head_slot])
                            : (price_r[i] > price_r[head_slot])) begin
          head_slot = slot_t'(i);
        end
      end
    end
  end

  // Lowest free slot takes the next insert
  always_comb begin
    free_found = 1'b0;
    free_slot = '0;
    for (int i = 0; i < DEPTH; i++) begin
      if (!vld_r[i] && !free_found) begin
        free_found = 1'b1;
        free_slot = slot_t'(i);
      end
    end
  end

  assign full = ~free_found;

  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      cancel_match[i] = vld_r[i] & (uid_r[i] == cancel_uid);
    end
  end

  // Empty side reads as all zero
  assign head_uid = head_vld ? uid_r[head_slot] : '0;
  assign head_price = head_vld ? price_r[head_slot] : '0;
  assign head_quantity = head_vld ? qty_r[head_slot] : '0;

  // Slot occupancy and the registered cancel result
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_r <= '0;
      cancel_hit <= 1'b0;
    end else begin
      if (insert) vld_r[free_slot] <= 1'b1;
      if (pop_head) vld_r[head_slot] <= 1'b0;
      if (cancel) begin
        vld_r <= vld_r & ~cancel_match;
        cancel_hit <= |cancel_match;
      end
    end
  end

  // Entry payload
  always_ff @(posedge clk) begin
    if (insert) begin
      uid_r[free_slot] <= ins_uid;
      price_r[free_slot] <= ins_price;
      qty_r[free_slot] <= ins_quantity;
    end
    if (head_update) qty_r[head_slot] <= head_quantity_new;
  end

  // Controller checks for room before inserting
  a_no_insert_full: assert property (
    @(posedge clk) disable iff (!rst_n) insert |-> !full)
    else $error("insert into a full book side");

endmodule

//--- verilog/ob_execute.sv
`timescale 1ns/1ps

module ob_execute import ob_pkg::*, ob_cntrl_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     rsp_full,
  ob_op_if.execute op,
  ob_evt_if.execute evt
);

  cntrl_state_t state_r, state_w;
  logic bid_insert, ask_insert, bid_pop, ask_pop, bid_update, ask_update;
  logic book_cancel, bid_cancel_hit, ask_cancel_hit, bid_full, ask_full;
  logic bid_head_vld, ask_head_vld, ins_ask, side_full, cross_r;
  uid_t bid_head_uid, ask_head_uid;
  price_t bid_head_price, ask_head_price;
  quantity_t bid_head_qty, ask_head_qty, bid_left, ask_left, trade_qty_r;

  ob_book_side #(.IS_ASK(1'b0)) u_bid (
    .clk(clk), .rst_n(rst_n),
    .insert(bid_insert), .ins_uid(op.op_uid), .ins_price(op.op_price),
    .ins_quantity(op.op_quantity), .pop_head(bid_pop),
    .head_update(bid_update), .head_quantity_new(bid_left),
    .cancel(book_cancel), .cancel_uid(op.op_uid1), .cancel_hit(bid_cancel_hit),
    .full(bid_full), .head_vld(bid_head_vld), .head_uid(bid_head_uid),
    .head_price(bid_head_price), .head_quantity(bid_head_qty)
  );

  ob_book_side #(.IS_ASK(1'b1)) u_ask (
    .clk(clk), .rst_n(rst_n),
    .insert(ask_insert), .ins_uid(op.op_uid), .ins_price(op.op_price),
    .ins_quantity(op.op_quantity), .pop_head(ask_pop),
    .head_update(ask_update), .head_quantity_new(ask_left),
    .cancel(book_cancel), .cancel_uid(op.op_uid1), .cancel_hit(ask_cancel_hit),
    .full(ask_full), .head_vld(ask_head_vld), .head_uid(ask_head_uid),
    .head_price(ask_head_price), .head_quantity(ask_head_qty)
  );

  assign ins_ask = (op.op_kind == OPK_INSERT_ASK);
  assign side_full = ins_ask ? ask_full : bid_full;
  // Head remainders after the registered trade
  assign bid_left = bid_head_qty - trade_qty_r;
  assign ask_left = ask_head_qty - trade_qty_r;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_r <= IDLE;
      cross_r <= 1'b0;
    end else begin
      state_r <= state_w;
      if (state_r == MATCH_QRY) begin
        cross_r <= bid_head_vld & ask_head_vld & (bid_head_price >= ask_head_price);
      end
    end
  end

  // Trade size is the smaller head
  always_ff @(posedge clk) begin
    if (state_r == MATCH_QRY) begin
      trade_qty_r <= (bid_head_qty < ask_head_qty) ? bid_head_qty : ask_head_qty;
    end
  end

  always_comb begin
    state_w = state_r;
    op.op_done = 1'b0;
    {bid_insert, ask_insert, bid_pop, ask_pop} = '0;
    {bid_update, ask_update, book_cancel} = '0;
    evt.evt_vld = 1'b0;
    evt.evt_kind = EVK_STATUS;
    evt.evt_status = S_OKAY;
    evt.evt_uid = op.op_uid;
    evt.evt_uid1 = '0;
    evt.evt_price_bid = bid_head_price;
    evt.evt_price_ask = ask_head_price;
    evt.evt_quantity = '0;
    // Nothing moves while the response port is full
    if (!rsp_full) begin
      case (state_r)
        IDLE: if (op.op_vld) begin
          case (op.op_kind)
            OPK_SPREAD: begin
              evt.evt_vld = 1'b1;
              op.op_done = 1'b1;
              evt.evt_kind = EVK_SPREAD;
              evt.evt_status = (bid_head_vld && ask_head_vld) ? S_OKAY : S_BAD;
            end
            OPK_INSERT_BID, OPK_INSERT_ASK: begin
              evt.evt_vld = 1'b1;
              if (side_full) begin
                evt.evt_status = S_REJECT;
                op.op_done = 1'b1;
              end else begin
                bid_insert = ~ins_ask;
                ask_insert = ins_ask;
                state_w = MATCH_QRY;
              end
            end
            OPK_POP_BID: begin
              evt.evt_vld = 1'b1;
              op.op_done = 1'b1;
              evt.evt_kind = EVK_ENTRY;
              evt.evt_status = bid_head_vld ? S_OKAY : S_BAD_POP;
              evt.evt_uid1 = bid_head_uid;
              evt.evt_price_ask = '0;
              evt.evt_quantity = bid_head_qty;
              bid_pop = bid_head_vld;
            end
            OPK_POP_ASK: begin
              evt.evt_vld = 1'b1;
              op.op_done = 1'b1;
              evt.evt_kind = EVK_ENTRY;
              evt.evt_status = ask_head_vld ? S_OKAY : S_BAD_POP;
              evt.evt_uid1 = ask_head_uid;
              evt.evt_price_bid = '0;
              evt.evt_quantity = ask_head_qty;
              ask_pop = ask_head_vld;
            end
            // Search both sides, answer next cycle
            OPK_CANCEL: begin
              book_cancel = 1'b1;
              state_w = CANCEL_RESP;
            end
            default: begin
              evt.evt_vld = 1'b1;
              op.op_done = 1'b1;
              evt.evt_status = (op.op_kind == OPK_BAD) ? S_BAD : S_OKAY;
            end
          endcase
        end
        CANCEL_RESP: begin
          evt.evt_vld = 1'b1;
          op.op_done = 1'b1;
          evt.evt_status = (bid_cancel_hit || ask_cancel_hit) ? S_CANCEL_HIT : S_CANCEL_MISS;
          state_w = IDLE;
        end
        MATCH_QRY: state_w = MATCH_EXEC;
        default: begin
          if (cross_r) begin
            // Trade at the ask price, bid uid first
            evt.evt_vld = 1'b1;
            evt.evt_kind = EVK_TRADE;
            evt.evt_status = S_TRADE;
            evt.evt_uid = bid_head_uid;
            evt.evt_uid1 = ask_head_uid;
            evt.evt_quantity = trade_qty_r;
            bid_pop = (bid_left == '0);
            ask_pop = (ask_left == '0);
            bid_update = ~bid_pop;
            ask_update = ~ask_pop;
            state_w = MATCH_QRY;
          end else begin
            op.op_done = 1'b1;
            state_w = IDLE;
          end
        end
      endcase
    end
  end

endmodule

//--- verilog/ob_result.sv
`timescale 1ns/1ps

module ob_result import ob_pkg::*, ob_cntrl_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  ob_evt_if.result  evt,
  output logic      rsp_vld,
  output uid_t      rsp_uid,
  output uid_t      rsp_uid1,
  output status_t   rsp_status,
  output price_t    rsp_bid_price,
  output price_t    rsp_ask_price,
  output quantity_t rsp_quantity
);

  // Response strobe, one cycle behind the event
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rsp_vld <= 1'b0;
    end else begin
      rsp_vld <= evt.evt_vld;
    end
  end

  // Response payload, unused fields zeroed per kind
  always_ff @(posedge clk) begin
    if (evt.evt_vld) begin
      rsp_uid <= evt.evt_uid;
      rsp_status <= evt.evt_status;
      rsp_uid1 <= '0;
      rsp_bid_price <= '0;
      rsp_ask_price <= '0;
      rsp_quantity <= '0;
      case (evt.evt_kind)
        EVK_SPREAD: begin
          rsp_bid_price <= evt.evt_price_bid;
          rsp_ask_price <= evt.evt_price_ask;
        end
        // Other side's price already zero
        EVK_ENTRY: begin
          rsp_uid1 <= evt.evt_uid1;
          rsp_bid_price <= evt.evt_price_bid;
          rsp_ask_price <= evt.evt_price_ask;
          rsp_quantity <= evt.evt_quantity;
        end
        // Both sides trade at the ask price
        EVK_TRADE: begin
          rsp_uid1 <= evt.evt_uid1;
          rsp_bid_price <= evt.evt_price_ask;
          rsp_ask_price <= evt.evt_price_ask;
          rsp_quantity <= evt.evt_quantity;
        end
        default: begin
        end
      endcase
    end
  end

  a_status_known: assert property (
    @(posedge clk) disable iff (!rst_n) rsp_vld |-> !$isunknown(rsp_status))
    else $error("rsp_status unknown on rsp_vld");

endmodule

//--- verilog/ob_top.sv
`timescale 1ns/1ps

module ob_top import ob_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  // Command port
  input  logic      cmd_vld,
  input  opcode_t   cmd_opcode,
  input  uid_t      cmd_uid,
  input  uid_t      cmd_uid1,
  input  price_t    cmd_price,
  input  quantity_t cmd_quantity,
  output logic      cmd_pop,
  // Response port
  input  logic      rsp_full,
  output logic      rsp_vld,
  output uid_t      rsp_uid,
  output uid_t      rsp_uid1,
  output status_t   rsp_status,
  output price_t    rsp_bid_price,
  output price_t    rsp_ask_price,
  output quantity_t rsp_quantity
);

  ob_op_if u_op_if ();
  ob_evt_if u_evt_if ();

  // Command latch and opcode mapping
  ob_decode u_decode (
    .clk(clk),
    .rst_n(rst_n),
    .cmd_vld(cmd_vld),
    .cmd_opcode(cmd_opcode),
    .cmd_uid(cmd_uid),
    .cmd_uid1(cmd_uid1),
    .cmd_price(cmd_price),
    .cmd_quantity(cmd_quantity),
    .cmd_pop(cmd_pop),
    .op(u_op_if.decode)
  );

  // Books and controller
  ob_execute u_execute (
    .clk(clk),
    .rst_n(rst_n),
    .rsp_full(rsp_full),
    .op(u_op_if.execute),
    .evt(u_evt_if.execute)
  );

  ob_result u_result (
    .clk(clk),
    .rst_n(rst_n),
    .evt(u_evt_if.result),
    .rsp_vld(rsp_vld),
    .rsp_uid(rsp_uid),
    .rsp_uid1(rsp_uid1),
    .rsp_status(rsp_status),
    .rsp_bid_price(rsp_bid_price),
    .rsp_ask_price(rsp_ask_price),
    .rsp_quantity(rsp_quantity)
  );

endmodule

//--- bench/ob_checker.sv
`timescale 1ns/1ps

module ob_checker import ob_pkg::*; (
  input logic      clk,
  input logic      rst_n,
  input logic      rsp_vld,
  input uid_t      rsp_uid,
  input uid_t      rsp_uid1,
  input status_t   rsp_status,
  input price_t    rsp_bid_price,
  input price_t    rsp_ask_price,
  input quantity_t rsp_quantity
);

  // One expected response, field order as on the port
  typedef struct packed {
    uid_t      uid;
    uid_t      uid1;
    status_t   status;
    price_t    bid_price;
    price_t    ask_price;
    quantity_t qty;
  } rsp_t;

  localparam int DRAIN_LIMIT = 400;

  rsp_t exp_q [$];
  rsp_t want_rsp;
  int error_count = 0;
  int test_count = 0;
  int test_rsp = 0;
  int test_err = 0;
  int total_rsp = 0;

  task automatic push_expected(input rsp_t e);
    exp_q.push_back(e);
  endtask

  task automatic check_field(input string name, input logic [15:0] got,
                             input logic [15:0] want);
    if (got !== want) begin
      $display("error at %0t ns: %s got 0x%0h, expected 0x%0h", $time, name, got, want);
      error_count++;
      test_err++;
    end
  endtask

  // Outputs settle after the rising edge, so look at the falling one
  always @(negedge clk) begin
    if (!rst_n) begin
      if (rsp_vld !== 1'b0) begin
        $display("rsp_vld was not low during reset at %0t ns", $time);
        error_count++;
        test_err++;
      end
    end else if ($isunknown(rsp_vld)) begin
      $display("rsp_vld is unknown at %0t ns", $time);
      error_count++;
      test_err++;
    end else if (rsp_vld) begin
      if (exp_q.size() == 0) begin
        $display("response at %0t ns arrived while none was expected", $time);
        error_count++;
        test_err++;
      end else begin
        want_rsp = exp_q.pop_front();
        check_field("rsp_uid", rsp_uid, want_rsp.uid);
        check_field("rsp_uid1", rsp_uid1, want_rsp.uid1);
        check_field("rsp_status", rsp_status, want_rsp.status);
        check_field("rsp_bid_price", rsp_bid_price, want_rsp.bid_price);
        check_field("rsp_ask_price", rsp_ask_price, want_rsp.ask_price);
        check_field("rsp_quantity", rsp_quantity, want_rsp.qty);
        test_rsp++;
        total_rsp++;
      end
    end
  end

  // Drain the queue, then one line for the test
  task automatic end_test(input string name);
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("test %s: %0d responses never arrived", name, exp_q.size());
      error_count++;
      test_err++;
      exp_q.delete();
    end
    $display("test %-8s finished: %0d responses, %0d errors", name, test_rsp, test_err);
    test_count++;
    test_rsp = 0;
    test_err = 0;
  endtask

  task automatic report_counts(input int stalls);
    $display("summary: %0d tests, %0d responses, %0d errors, %0d stalled commands",
             test_count, total_rsp, error_count, stalls);
  endtask

endmodule

//--- bench/tb_ob_top.sv
`timescale 1ns/1ps
`include "ob_config.svh"

module tb_ob_top import ob_pkg::*; ();

  localparam int DEPTH = `OB_BOOK_DEPTH;
  localparam int CMD_TIMEOUT = 200;

  typedef struct packed {
    uid_t      uid;
    uid_t      uid1;
    status_t   status;
    price_t    bid_price;
    price_t    ask_price;
    quantity_t qty;
  } exp_rsp_t;

  logic clk, rst_n, cmd_vld, cmd_pop, rsp_full, rsp_vld;
  opcode_t cmd_opcode;
  uid_t cmd_uid, cmd_uid1, rsp_uid, rsp_uid1;
  price_t cmd_price, rsp_bid_price, rsp_ask_price;
  quantity_t cmd_quantity, rsp_quantity;
  status_t rsp_status;

  // Reference books, side 0 bid and side 1 ask
  logic m_vld [2][DEPTH];
  uid_t m_uid [2][DEPTH];
  price_t m_price [2][DEPTH];
  quantity_t m_qty [2][DEPTH];
  exp_rsp_t exp_q [$];
  logic full_random;
  logic aborted;
  int stalls;

  ob_top u_dut (.*);

  ob_checker u_checker (
    .clk(clk), .rst_n(rst_n), .rsp_vld(rsp_vld), .rsp_uid(rsp_uid),
    .rsp_uid1(rsp_uid1), .rsp_status(rsp_status), .rsp_bid_price(rsp_bid_price),
    .rsp_ask_price(rsp_ask_price), .rsp_quantity(rsp_quantity)
  );

  always #50 clk = ~clk;

  // Random back-pressure on the response port
  always @(posedge clk) begin
    rsp_full <= full_random ? ($urandom_range(0, 2) == 0) : 1'b0;
  end

  // Best price, lowest slot on ties, -1 when empty
  function automatic int head_of(int s);
    int h;
    h = -1;
    for (int i = 0; i < DEPTH; i++) begin
      if (m_vld[s][i] && (h < 0 || (s == 1 ? m_price[s][i] < m_price[s][h]
                                           : m_price[s][i] > m_price[s][h]))) begin
        h = i;
      end
    end
    return h;
  endfunction

  function automatic void put(uid_t u, uid_t u1, status_t st, price_t bp, price_t ap,
                              quantity_t q);
    exp_rsp_t e;
    e = '{u, u1, st, bp, ap, q};
    exp_q.push_back(e);
  endfunction

  // Expected responses of one command, books updated in place
  function automatic void ref_model(opcode_t opc, uid_t uid, uid_t uid1, price_t price,
                                    quantity_t qty);
    int s, b, a, f;
    logic hit;
    quantity_t q;
    b = head_of(0);
    a = head_of(1);
    case (opc)
      OP_NOP: put(uid, 0, S_OKAY, 0, 0, 0);
      // Empty head reads as price zero
      OP_QRY_BID_ASK: put(uid, 0, (b >= 0 && a >= 0) ? S_OKAY : S_BAD,
                          (b >= 0) ? m_price[0][b] : 0, (a >= 0) ? m_price[1][a] : 0, 0);
      OP_POP_TOP_BID, OP_POP_TOP_ASK: begin
        s = (opc == OP_POP_TOP_ASK);
        f = head_of(s);
        if (f < 0) begin
          put(uid, 0, S_BAD_POP, 0, 0, 0);
        end else begin
          put(uid, m_uid[s][f], S_OKAY, s ? 0 : m_price[s][f], s ? m_price[s][f] : 0,
              m_qty[s][f]);
          m_vld[s][f] = 1'b0;
        end
      end
      OP_BUY_LIMIT, OP_SELL_LIMIT: begin
        s = (opc == OP_SELL_LIMIT);
        f = -1;
        // Lowest free slot
        for (int i = DEPTH - 1; i >= 0; i--) begin
          if (!m_vld[s][i]) f = i;
        end
        if (f < 0) begin
          put(uid, 0, S_REJECT, 0, 0, 0);
        end else begin
          m_vld[s][f] = 1'b1;
          m_uid[s][f] = uid;
          m_price[s][f] = price;
          m_qty[s][f] = qty;
          put(uid, 0, S_OKAY, 0, 0, 0);
          b = head_of(0);
          a = head_of(1);
          // Trade the heads at the ask price while they cross
          while (b >= 0 && a >= 0 && m_price[0][b] >= m_price[1][a]) begin
            q = (m_qty[0][b] < m_qty[1][a]) ? m_qty[0][b] : m_qty[1][a];
            put(m_uid[0][b], m_uid[1][a], S_TRADE, m_price[1][a], m_price[1][a], q);
            m_qty[0][b] -= q;
            m_qty[1][a] -= q;
            if (m_qty[0][b] == 0) m_vld[0][b] = 1'b0;
            if (m_qty[1][a] == 0) m_vld[1][a] = 1'b0;
            b = head_of(0);
            a = head_of(1);
          end
        end
      end
      // Target uid in uid1, searched on both sides
      OP_CANCEL: begin
        hit = 1'b0;
        for (int k = 0; k < 2; k++) begin
          for (int i = 0; i < DEPTH; i++) begin
            if (m_vld[k][i] && m_uid[k][i] == uid1) begin
              hit = 1'b1;
              m_vld[k][i] = 1'b0;
            end
          end
        end
        put(uid, 0, hit ? S_CANCEL_HIT : S_CANCEL_MISS, 0, 0, 0);
      end
      default: put(uid, 0, S_BAD, 0, 0, 0);
    endcase
  endfunction

  // Present one command and hold it until cmd_pop
  task automatic send_cmd(opcode_t opc, uid_t uid, uid_t uid1, price_t price,
                          quantity_t qty);
    int waited;
    if (!aborted) begin
      ref_model(opc, uid, uid1, price, qty);
      while (exp_q.size() != 0) begin
        u_checker.push_expected(exp_q.pop_front());
      end
      @(posedge clk);
      cmd_vld <= 1'b1;
      cmd_opcode <= opc;
      cmd_uid <= uid;
      cmd_uid1 <= uid1;
      cmd_price <= price;
      cmd_quantity <= qty;
      waited = 0;
      do begin
        @(negedge clk);
        waited++;
      end while (cmd_pop !== 1'b1 && waited < CMD_TIMEOUT);
      if (cmd_pop !== 1'b1) begin
        $display("command %0d with uid %0d was not taken within %0d cycles",
                 opc, uid, CMD_TIMEOUT);
        stalls++;
        aborted = 1'b1;
      end
      @(posedge clk);
      cmd_vld <= 1'b0;
    end
  endtask

  // Small ranges so that prices cross and uids repeat
  task automatic send_random_cmd();
    opcode_t opc;
    uid_t uid, uid1;
    price_t price;
    quantity_t qty;
    opc = opcode_t'($urandom_range(0, 7));
    uid = uid_t'($urandom_range(1, 15));
    uid1 = uid_t'($urandom_range(1, 15));
    price = price_t'($urandom_range(95, 105));
    qty = quantity_t'($urandom_range(1, 20));
    send_cmd(opc, uid, uid1, price, qty);
  endtask

  initial begin
    void'($urandom(13061));
    clk = 1'b0;
    rst_n = 1'b0;
    cmd_vld = 1'b0;
    cmd_opcode = OP_NOP;
    cmd_uid = '0;
    cmd_uid1 = '0;
    cmd_price = '0;
    cmd_quantity = '0;
    rsp_full = 1'b0;
    full_random = 1'b0;
    aborted = 1'b0;
    stalls = 0;
    for (int k = 0; k < 2; k++) begin
      for (int i = 0; i < DEPTH; i++) begin
        m_vld[k][i] = 1'b0;
      end
    end
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    // No-op and unknown codes
    send_cmd(OP_NOP, 1, 0, 0, 0);
    send_cmd(opcode_t'(9), 2, 0, 0, 0);
    send_cmd(opcode_t'(15), 3, 0, 0, 0);
    u_checker.end_test("nop_bad");

    // Spread on empty, one-sided and two-sided books
    send_cmd(OP_QRY_BID_ASK, 4, 0, 0, 0);
    send_cmd(OP_BUY_LIMIT, 10, 0, 100, 5);
    send_cmd(OP_QRY_BID_ASK, 5, 0, 0, 0);
    send_cmd(OP_SELL_LIMIT, 11, 0, 110, 5);
    send_cmd(OP_QRY_BID_ASK, 6, 0, 0, 0);
    u_checker.end_test("spread");

    // Crossing inserts, remainders shown by pops
    send_cmd(OP_SELL_LIMIT, 12, 0, 105, 3);
    send_cmd(OP_BUY_LIMIT, 13, 0, 108, 8);
    send_cmd(OP_SELL_LIMIT, 14, 0, 100, 12);
    send_cmd(OP_POP_TOP_ASK, 15, 0, 0, 0);
    send_cmd(OP_POP_TOP_ASK, 16, 0, 0, 0);
    u_checker.end_test("cross");

    // Price then slot priority on a full bid side
    send_cmd(OP_BUY_LIMIT, 20, 0, 50, 1);
    send_cmd(OP_BUY_LIMIT, 21, 0, 60, 2);
    send_cmd(OP_BUY_LIMIT, 22, 0, 60, 3);
    send_cmd(OP_BUY_LIMIT, 23, 0, 55, 4);
    for (int n = 0; n < DEPTH + 1; n++) begin
      send_cmd(OP_POP_TOP_BID, uid_t'(24 + n), 0, 0, 0);
    end
    send_cmd(OP_POP_TOP_ASK, 29, 0, 0, 0);
    u_checker.end_test("pop");

    // Full side rejects, cancel hit and miss
    for (int n = 0; n < DEPTH + 1; n++) begin
      send_cmd(OP_SELL_LIMIT, uid_t'(30 + n), 0, 200, 1);
    end
    send_cmd(OP_CANCEL, 40, 31, 0, 0);
    send_cmd(OP_CANCEL, 41, 31, 0, 0);
    send_cmd(OP_CANCEL, 42, 99, 0, 0);
    send_cmd(OP_BUY_LIMIT, 35, 0, 150, 2);
    send_cmd(OP_CANCEL, 43, 35, 0, 0);
    u_checker.end_test("cancel");

    // Random commands under back-pressure
    full_random <= 1'b1;
    repeat (200) send_random_cmd();
    full_random <= 1'b0;
    u_checker.end_test("random");

    u_checker.report_counts(stalls);
    if (u_checker.error_count == 0 && stalls == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+verilog
verilog/ob_pkg.sv
verilog/ob_cntrl_pkg.sv
verilog/ob_cntrl_if.sv
verilog/ob_decode.sv
verilog/ob_book_side.sv
verilog/ob_execute.sv
verilog/ob_result.sv
verilog/ob_top.sv
bench/ob_checker.sv
bench/tb_ob_top.sv

//--- Bender.yml
package:
  name: ob_top

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/ob_pkg.sv
      - verilog/ob_cntrl_pkg.sv
      - verilog/ob_cntrl_if.sv
      - verilog/ob_decode.sv
      - verilog/ob_book_side.sv
      - verilog/ob_execute.sv
      - verilog/ob_result.sv
      - verilog/ob_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/ob_checker.sv
      - bench/tb_ob_top.sv
